// ==== tb.f ====
rtl/i2c_pkg.sv
rtl/i2c_regs.sv
rtl/i2c_buffer.sv
rtl/i2c_sequencer.sv
rtl/i2c_byte_shifter.sv
rtl/i2c_master_top.sv
verif/i2c_target_model.sv
verif/tb_i2c_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_i2c_master
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_i2c_master.sv ====
// Testbench for i2c_master_top with a target at 7'h50. Stops at the first error.
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

    localparam int         NROWS   = 7;
    localparam int         DEPTH   = 16;
    localparam logic [6:0] TARGET  = 7'h50;
    localparam count_t     NO_NACK = 16'hffff;

    typedef struct packed {
        byte_t  addr;
        count_t size;
        byte_t  mix;       // xor applied to the random data.
        count_t nack_pos;
    } row_t;

    logic        I2C_CLK;
    logic        RST;
    bus_addr_t   bus_add;
    byte_t       bus_data_in;
    byte_t       bus_data_out;
    logic        bus_wr;
    logic        bus_rd;
    logic        scl_oe;
    logic        sda_oe;
    logic        sda_in;
    logic        model_rst;
    count_t      nack_pos;
    logic        load_en;
    byte_t       load_idx;
    byte_t       load_data;
    row_t        rows [NROWS];
    string       names [NROWS];
    byte_t       data_q [DEPTH];
    integer      seed;
    longint      limit;

    i2c_master_top #(
        .MEM_BYTES  (DEPTH),
        .ABUS_WIDTH (16)
    ) i_dut (
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe),
        .sda_in       (sda_in),
        .I2C_CLK      (I2C_CLK),
        .RST          (RST)
    );

    i2c_target_model #(.ADDR(TARGET)) i_target (
        .clk       (I2C_CLK),
        .rst       (RST || model_rst),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in),
        .nack_pos  (nack_pos),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data)
    );

    initial begin
        I2C_CLK = 1'b0;
        forever #10 I2C_CLK = ~I2C_CLK;
    end

    // ********************
    // checks
    // ********************

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_status(input string name, input i2c_status_t exp,
                                input i2c_status_t act);
        if (exp !== act) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic watchdog(input longint ns);
        #(ns);
        $display("timeout: the test did not finish within %0d ns", ns);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    endtask

    // ********************
    // host bus
    // ********************

    task automatic bus_write(input bus_addr_t a, input byte_t d);
        @(posedge I2C_CLK);
        bus_add     <= a;
        bus_data_in <= d;
        bus_wr      <= 1'b1;
        @(posedge I2C_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output byte_t d);
        @(posedge I2C_CLK);
        bus_add <= a;
        bus_rd  <= 1'b1;
        @(posedge I2C_CLK);
        bus_rd <= 1'b0;
        @(negedge I2C_CLK);
        d = bus_data_out;   // one cycle after the strobe.
    endtask

    task automatic read_status(output i2c_status_t s);
        byte_t b;
        bus_read(16'd1, b);
        s = i2c_status_t'(b[1:0]);
    endtask

    task automatic wait_done(output i2c_status_t s);
        s = '0;
        while (!s.done)
            read_status(s);
    endtask

    task automatic reset_target();
        @(posedge I2C_CLK);
        model_rst <= 1'b1;
        @(posedge I2C_CLK);
        model_rst <= 1'b0;
    endtask

    task automatic load_target(input count_t n);
        for (int i = 0; i < int'(n); i++) begin
            @(posedge I2C_CLK);
            load_en   <= 1'b1;
            load_idx  <= byte_t'(i);
            load_data <= data_q[i];
        end
        @(posedge I2C_CLK);
        load_en <= 1'b0;
    endtask

    task automatic make_data(input int r);
        for (int i = 0; i < DEPTH; i++)
            data_q[i] = byte_t'($random(seed)) ^ rows[r].mix;
    endtask

    task automatic fill_table();
        rows[0] = '{addr: 8'ha0, size: 16'd4,  mix: 8'h00, nack_pos: NO_NACK};
        rows[1] = '{addr: 8'ha1, size: 16'd5,  mix: 8'h5a, nack_pos: NO_NACK};
        rows[2] = '{addr: 8'hb0, size: 16'd3,  mix: 8'h00, nack_pos: NO_NACK};
        rows[3] = '{addr: 8'ha0, size: 16'd6,  mix: 8'hff, nack_pos: 16'd2};
        rows[4] = '{addr: 8'ha0, size: 16'd16, mix: 8'h33, nack_pos: NO_NACK};
        rows[5] = '{addr: 8'ha1, size: 16'd1,  mix: 8'h0f, nack_pos: NO_NACK};
        rows[6] = '{addr: 8'ha0, size: 16'd4,  mix: 8'hc3, nack_pos: NO_NACK};
        names[0] = "write4";
        names[1] = "read5";
        names[2] = "wrong_addr";
        names[3] = "write_nack2";
        names[4] = "write16";
        names[5] = "read1";
        names[6] = "write_after_soft_reset";
    endtask

    task automatic start_transfer(input row_t row);
        bus_write(16'd2, row.addr);
        bus_write(16'd3, row.size[7:0]);
        bus_write(16'd4, row.size[15:8]);
        bus_write(16'd1, 8'h00);
    endtask

    task automatic run_row(input int r);
        row_t        row;
        logic        match;
        logic        nacked;
        count_t      n_expected;
        count_t      stops;
        i2c_status_t st;
        i2c_status_t exp_st;
        byte_t       b;
        row        = rows[r];
        match      = (row.addr[7:1] == TARGET);
        nacked     = !row.addr[0] && (row.nack_pos < row.size);
        n_expected = nacked ? row.nack_pos + 16'd1 : row.size;
        make_data(r);
        @(posedge I2C_CLK);
        nack_pos <= row.nack_pos;
        if (row.addr[0]) begin
            load_target(row.size);
        end else begin
            for (int i = 0; i < int'(row.size); i++)
                bus_write(bus_addr_t'(8 + i), data_q[i]);
        end
        stops = i_target.stop_cnt;
        start_transfer(row);
        wait_done(st);
        exp_st.no_ack = !match || nacked;
        exp_st.done   = 1'b1;
        check_status(names[r], exp_st, st);
        if (!match) begin
            check_count(names[r], 16'd0, i_target.wr_cnt);
            check_count(names[r], stops, i_target.stop_cnt);
        end else if (row.addr[0]) begin
            for (int i = 0; i < int'(row.size); i++) begin
                bus_read(bus_addr_t'(8 + i), b);
                check_byte(names[r], data_q[i], b);
                check_count(names[r], count_t'(i == int'(row.size) - 1),
                            count_t'(i_target.acks[i]));
            end
            check_count(names[r], row.size, i_target.rd_cnt);
            check_count(names[r], stops + 16'd1, i_target.stop_cnt);
        end else begin
            for (int i = 0; i < int'(n_expected); i++)
                check_byte(names[r], data_q[i], i_target.mem[i]);
            check_count(names[r], n_expected, i_target.wr_cnt);
            check_count(names[r], stops + 16'd1, i_target.stop_cnt);
        end
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        i2c_status_t st;
        i2c_status_t exp_st;
        byte_t       b;
        byte_t       regs_w [8];
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        model_rst   = 1'b0;
        nack_pos    = NO_NACK;
        load_en     = 1'b0;
        load_idx    = '0;
        load_data   = '0;
        seed        = 32'hc1f;
        fill_table();
        limit = 0;
        for (int r = 0; r < NROWS; r++)
            limit = limit + (longint'(rows[r].size) + 3) * 9 * 4 * 20 * 2;
        limit = limit + (8 + 3) * 9 * 4 * 20 * 2;   // the aborted transfer.
        fork
            watchdog(limit);
        join_none
        repeat (2) @(posedge I2C_CLK);
        RST <= 1'b0;

        bus_read(16'd0, b);
        check_byte("version", 8'd1, b);
        read_status(st);
        exp_st.no_ack = 1'b0;
        exp_st.done   = 1'b1;
        check_status("status_after_reset", exp_st, st);
        for (int a = 2; a < 8; a++) begin
            regs_w[a] = byte_t'($random(seed));
            bus_write(bus_addr_t'(a), regs_w[a]);
        end
        for (int a = 2; a < 8; a++) begin
            bus_read(bus_addr_t'(a), b);
            check_byte("register_readback", regs_w[a], b);
        end
        make_data(0);
        for (int i = 0; i < DEPTH; i++)
            bus_write(bus_addr_t'(8 + i), data_q[i]);
        for (int i = 0; i < DEPTH; i++) begin
            bus_read(bus_addr_t'(8 + i), b);
            check_byte("buffer_readback", data_q[i], b);
        end

        for (int r = 0; r < NROWS - 1; r++)
            run_row(r);

        // soft reset in the middle of an eight byte write.
        reset_target();
        for (int i = 0; i < 8; i++)
            bus_write(bus_addr_t'(8 + i), data_q[i]);
        nack_pos <= NO_NACK;
        bus_write(16'd2, 8'ha0);
        bus_write(16'd3, 8'd8);
        bus_write(16'd4, 8'd0);
        bus_write(16'd1, 8'h00);
        while (i_target.wr_cnt < 16'd2)
            @(posedge I2C_CLK);
        bus_write(16'd0, 8'h00);
        @(negedge I2C_CLK);
        check_byte("soft_reset_lines", 8'h00, {6'd0, scl_oe, sda_oe});
        reset_target();
        read_status(st);
        check_status("soft_reset_status", exp_st, st);
        run_row(NROWS - 1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/i2c_target_model.sv ====
// I2C target sampled on the system clock. 7-bit address only, 256 byte memory, no clock stretching.
`timescale 1ns/100ps
`default_nettype none

module i2c_target_model
    import i2c_pkg::*;
#(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         scl_oe,
    input  wire         sda_oe,
    output logic        sda_in,
    input  wire count_t nack_pos,
    input  wire         load_en,
    input  wire byte_t  load_idx,
    input  wire byte_t  load_data
);

    typedef enum logic [2:0] {
        T_IDLE,
        T_ADDR,
        T_WRITE,
        T_READ,
        T_IGNORE
    } tgt_state_e;

    tgt_state_e state;
    logic       scl;
    logic       sda;
    logic       scl_q;
    logic       sda_q;
    logic       drive_low;
    logic       skip_fall;   // the SCL fall that closes the START.
    logic       mack;
    logic [3:0] bit_cnt;
    byte_t      shreg;
    byte_t      tx;
    byte_t      mem [256];
    logic       acks [256];
    count_t     wr_cnt;
    count_t     rd_cnt;
    count_t     stop_cnt;

    // wired-AND of the controller and the target.
    assign scl    = !scl_oe;
    assign sda    = !(sda_oe || drive_low);
    assign sda_in = sda;

    always @(posedge clk) begin
        scl_q <= scl;
        sda_q <= sda;
        if (load_en)
            mem[load_idx] <= load_data;
        if (rst) begin
            state     <= T_IDLE;
            drive_low <= 1'b0;
            skip_fall <= 1'b0;
            mack      <= 1'b0;
            bit_cnt   <= 4'd0;
            wr_cnt    <= 16'd0;
            rd_cnt    <= 16'd0;
            stop_cnt  <= 16'd0;
        end else if (scl && scl_q && sda_q && !sda) begin
            state     <= T_ADDR;   // START.
            bit_cnt   <= 4'd0;
            skip_fall <= 1'b1;
            mack      <= 1'b0;
            drive_low <= 1'b0;
            wr_cnt    <= 16'd0;
            rd_cnt    <= 16'd0;
        end else if (scl && scl_q && !sda_q && sda) begin
            state     <= T_IDLE;   // STOP.
            drive_low <= 1'b0;
            stop_cnt  <= stop_cnt + 16'd1;
        end else if (state inside {T_ADDR, T_WRITE, T_READ}) begin
            if (scl && !scl_q) begin
                if (bit_cnt != 4'd8) begin
                    shreg <= {shreg[6:0], sda};
                end else if (state == T_READ) begin
                    acks[rd_cnt[7:0] - 8'd1] <= sda;
                    mack <= sda;
                end
            end else if (!scl && scl_q) begin
                if (skip_fall) begin
                    skip_fall <= 1'b0;
                end else if (bit_cnt == 4'd7) begin
                    bit_cnt <= 4'd8;
                    case (state)
                        T_ADDR: begin
                            if (shreg[7:1] == ADDR) begin
                                drive_low <= 1'b1;
                                state     <= shreg[0] ? T_READ : T_WRITE;
                            end else begin
                                state <= T_IGNORE;
                            end
                        end
                        T_WRITE: begin
                            mem[wr_cnt[7:0]] <= shreg;
                            drive_low        <= (wr_cnt != nack_pos);
                            wr_cnt           <= wr_cnt + 16'd1;
                        end
                        default: drive_low <= 1'b0;   // the controller acks read bytes.
                    endcase
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt   <= 4'd0;
                    drive_low <= 1'b0;
                    if (state == T_READ) begin
                        if (mack) begin
                            state <= T_IGNORE;
                        end else begin
                            tx        <= mem[rd_cnt[7:0]];
                            drive_low <= !mem[rd_cnt[7:0]][7];
                            rd_cnt    <= rd_cnt + 16'd1;
                        end
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (state == T_READ) begin
                        drive_low <= !tx[6];
                        tx        <= {tx[6:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_master_top.sv ====
// Top level. Pads stay outside, scl_oe and sda_oe pull the lines low and sda_in is the resolved level.
`timescale 1ns/100ps
`default_nettype none

module i2c_master_top
    import i2c_pkg::*;
#(
    parameter int MEM_BYTES  = 16,
    parameter int ABUS_WIDTH = 16
) (
    input  wire bus_addr_t bus_add,
    input  wire byte_t     bus_data_in,
    input  wire            bus_wr,
    input  wire            bus_rd,
    output byte_t          bus_data_out,
    output logic           scl_oe,
    output logic           sda_oe,
    input  wire            sda_in,
    input  wire            I2C_CLK,
    input  wire            RST
);

    logic       mem_en;
    logic       mem_we;
    bus_addr_t  mem_add;
    byte_t      mem_wdata;
    byte_t      mem_rdata;
    i2c_cfg_t   cfg;
    logic       go;
    logic       soft_rst;
    logic       done_pulse;
    logic       no_ack_pulse;
    logic       ctl_en;
    logic       ctl_we;
    count_t     ctl_add;
    byte_t      ctl_wdata;
    byte_t      ctl_rdata;
    logic       req;
    shift_req_t req_data;
    logic       ack;
    shift_rsp_t rsp;
    logic       core_rst;

    assign core_rst = RST || soft_rst;   // a soft reset also frees both lines.

    i2c_regs #(
        .MEM_BYTES  (MEM_BYTES),
        .ABUS_WIDTH (ABUS_WIDTH)
    ) i_regs (
        .I2C_CLK      (I2C_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_add      (mem_add),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .cfg          (cfg),
        .go           (go),
        .soft_rst     (soft_rst),
        .done_pulse   (done_pulse),
        .no_ack_pulse (no_ack_pulse)
    );

    i2c_buffer #(
        .MEM_BYTES  (MEM_BYTES),
        .ABUS_WIDTH (ABUS_WIDTH)
    ) i_buffer (
        .I2C_CLK    (I2C_CLK),
        .host_en    (mem_en),
        .host_we    (mem_we),
        .host_add   (mem_add),
        .host_wdata (mem_wdata),
        .host_rdata (mem_rdata),
        .ctl_en     (ctl_en),
        .ctl_we     (ctl_we),
        .ctl_add    (ctl_add),
        .ctl_wdata  (ctl_wdata),
        .ctl_rdata  (ctl_rdata)
    );

    i2c_sequencer i_sequencer (
        .I2C_CLK      (I2C_CLK),
        .RST          (core_rst),
        .cfg          (cfg),
        .go           (go),
        .done_pulse   (done_pulse),
        .no_ack_pulse (no_ack_pulse),
        .ctl_en       (ctl_en),
        .ctl_we       (ctl_we),
        .ctl_add      (ctl_add),
        .ctl_wdata    (ctl_wdata),
        .ctl_rdata    (ctl_rdata),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .rsp          (rsp)
    );

    i2c_byte_shifter i_shifter (
        .I2C_CLK  (I2C_CLK),
        .RST      (core_rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

// ==== rtl/i2c_byte_shifter.sv ====
// Bit engine with four I2C_CLK cycles per bit. No clock stretching and no arbitration.
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_shifter
    import i2c_pkg::*;
(
    input  wire              I2C_CLK,
    input  wire              RST,
    input  wire              req,
    input  wire shift_req_t  req_data,
    output logic             ack,
    output shift_rsp_t       rsp,
    output logic             scl_oe,
    output logic             sda_oe,
    input  wire              sda_in
);

    logic [1:0] phase_q;
    logic [3:0] bit_q;      // 0 to 7 are data bits, 8 is the ACK bit.
    logic       active_q;
    shift_op_e  op_q;
    byte_t      shift_q;
    logic       ack_lvl_q;
    logic       nack_q;
    logic       accept;
    logic       sda_pull;
    logic       shape_op;

    // ops are taken only at the end of a bit so they start cleanly in phase 0.
    assign accept   = !active_q && (phase_q == 2'd3) && req && !ack;
    assign shape_op = active_q && ((op_q == OP_START) || (op_q == OP_STOP));
    assign rsp      = '{data: shift_q, nack: nack_q};

    always_comb begin
        case (op_q)
            OP_WRITE_BYTE: sda_pull = (bit_q == 4'd8) ? 1'b0 : !shift_q[7];
            OP_READ_BYTE:  sda_pull = (bit_q == 4'd8) ? !ack_lvl_q : 1'b0;
            default:       sda_pull = 1'b1;   // START and STOP both begin with SDA low.
        endcase
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            phase_q  <= '0;
            bit_q    <= '0;
            active_q <= 1'b0;
            ack      <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else begin
            phase_q <= phase_q + 2'd1;
            if (ack && !req)
                ack <= 1'b0;
            if (accept) begin
                active_q <= 1'b1;
                bit_q    <= '0;
            end else if (!active_q) begin
                if ((phase_q == 2'd3) && !req) begin
                    // nothing follows, so the bus is let go.
                    scl_oe <= 1'b0;
                    sda_oe <= 1'b0;
                end
            end else begin
                case (phase_q)
                    2'd0: sda_oe <= sda_pull;
                    2'd1: scl_oe <= 1'b0;
                    2'd3: begin
                        if (op_q == OP_STOP)
                            sda_oe <= 1'b0;   // SDA rises while SCL is high.
                        else
                            scl_oe <= 1'b1;
                        if (shape_op || (bit_q == 4'd8)) begin
                            active_q <= 1'b0;
                            ack      <= 1'b1;
                        end else begin
                            bit_q <= bit_q + 4'd1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (accept) begin
            op_q      <= req_data.op;
            shift_q   <= req_data.data;
            ack_lvl_q <= req_data.ack_lvl;
        end else if (active_q) begin
            if ((phase_q == 2'd1) && (bit_q == 4'd8))
                nack_q <= sda_in;
            if ((phase_q == 2'd3) && (bit_q != 4'd8))
                shift_q <= {shift_q[6:0], sda_in};
        end
    end

    a_sda_scl_low: assert property (@(posedge I2C_CLK) disable iff (RST)
        $changed(sda_oe) && !$past(RST) && !$past(shape_op) |-> $past(scl_oe));

endmodule

`default_nettype wire

// ==== rtl/i2c_sequencer.sv ====
// Transaction FSM. cfg must stay stable while busy, and go is ignored outside IDLE.
`timescale 1ns/100ps
`default_nettype none

module i2c_sequencer
    import i2c_pkg::*;
(
    input  wire              I2C_CLK,
    input  wire              RST,
    input  wire i2c_cfg_t    cfg,
    input  wire              go,
    output logic             done_pulse,
    output logic             no_ack_pulse,
    output logic             ctl_en,
    output logic             ctl_we,
    output count_t           ctl_add,
    output byte_t            ctl_wdata,
    input  wire byte_t       ctl_rdata,
    output logic             req,
    output shift_req_t       req_data,
    input  wire              ack,
    input  wire shift_rsp_t  rsp
);

    seq_state_e state_q;
    count_t     idx_q;
    count_t     idx_next;
    logic       rd_mode;
    logic       rd_last;
    logic       wr_last;
    logic       issue;
    logic       capture;
    logic       store;

    assign rd_mode  = cfg.addr[0];
    assign idx_next = idx_q + 16'd1;
    assign rd_last  = (idx_next == cfg.size);
    assign wr_last  = (idx_q == cfg.size);   // idx already points past the byte in flight.

    // ********************
    // handshake
    // ********************

    assign issue   = (state_q != SEQ_IDLE) && !req && !ack;
    assign capture = req && ack;
    assign store   = capture && (state_q == SEQ_DATA) && rd_mode;

    assign ctl_en    = store || ((state_q != SEQ_IDLE) && !rd_mode);
    assign ctl_we    = store;
    assign ctl_add   = idx_q;
    assign ctl_wdata = rsp.data;

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            state_q      <= SEQ_IDLE;
            idx_q        <= '0;
            req          <= 1'b0;
            done_pulse   <= 1'b0;
            no_ack_pulse <= 1'b0;
        end else begin
            done_pulse   <= 1'b0;
            no_ack_pulse <= 1'b0;
            if (issue) begin
                req <= 1'b1;
                if ((state_q == SEQ_DATA) && !rd_mode)
                    idx_q <= idx_next;   // fetch the next byte while this one shifts.
            end
            if (capture)
                req <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (go) begin
                        state_q <= SEQ_START;
                        idx_q   <= '0;
                    end
                end
                SEQ_START: begin
                    if (capture)
                        state_q <= SEQ_ADDR;
                end
                SEQ_ADDR: begin
                    if (capture) begin
                        if (rsp.nack) begin
                            // no target answered, so no data and no STOP.
                            no_ack_pulse <= 1'b1;
                            done_pulse   <= 1'b1;
                            state_q      <= SEQ_IDLE;
                        end else if (cfg.size == '0) begin
                            state_q <= SEQ_STOP;
                        end else begin
                            state_q <= SEQ_DATA;
                        end
                    end
                end
                SEQ_DATA: begin
                    if (capture) begin
                        if (rd_mode) begin
                            idx_q <= idx_next;
                            if (rd_last)
                                state_q <= SEQ_STOP;
                        end else if (rsp.nack) begin
                            no_ack_pulse <= 1'b1;
                            state_q      <= SEQ_STOP;
                        end else if (wr_last) begin
                            state_q <= SEQ_STOP;
                        end
                    end
                end
                SEQ_STOP: begin
                    if (capture) begin
                        done_pulse <= 1'b1;
                        state_q    <= SEQ_IDLE;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (issue) begin
            req_data.data    <= cfg.addr;
            req_data.ack_lvl <= 1'b0;
            case (state_q)
                SEQ_START: req_data.op <= OP_START;
                SEQ_ADDR:  req_data.op <= OP_WRITE_BYTE;
                SEQ_DATA: begin
                    req_data.op      <= rd_mode ? OP_READ_BYTE : OP_WRITE_BYTE;
                    req_data.data    <= ctl_rdata;
                    req_data.ack_lvl <= rd_last;   // the last read byte gets a NACK.
                end
                default:   req_data.op <= OP_STOP;
            endcase
        end
    end

    // the shifter answers only a request that is still held.
    a_ack_needs_req: assert property (@(posedge I2C_CLK) disable iff (RST)
        $rose(ack) |-> req);

endmodule

`default_nettype wire

// ==== rtl/i2c_buffer.sv ====
// Dual port byte buffer. MEM_BYTES must be a power of two and address bits above it are ignored.
`timescale 1ns/100ps
`default_nettype none

module i2c_buffer
    import i2c_pkg::*;
#(
    parameter int MEM_BYTES  = 16,
    parameter int ABUS_WIDTH = 16
) (
    input  wire                  I2C_CLK,
    input  wire                  host_en,
    input  wire                  host_we,
    input  wire [ABUS_WIDTH-1:0] host_add,
    input  wire byte_t           host_wdata,
    output byte_t                host_rdata,
    input  wire                  ctl_en,
    input  wire                  ctl_we,
    input  wire count_t          ctl_add,
    input  wire byte_t           ctl_wdata,
    output byte_t                ctl_rdata
);

    localparam int AW = $clog2(MEM_BYTES);

    byte_t         mem [MEM_BYTES];
    logic [AW-1:0] host_idx;
    logic [AW-1:0] ctl_idx;

    assign host_idx = host_add[AW-1:0];
    assign ctl_idx  = ctl_add[AW-1:0];

    // a write leaves the read data of its port unchanged.
    always_ff @(posedge I2C_CLK) begin
        if (host_en) begin
            if (host_we)
                mem[host_idx] <= host_wdata;
            else
                host_rdata <= mem[host_idx];
        end
        if (ctl_en) begin
            if (ctl_we)
                mem[ctl_idx] <= ctl_wdata;
            else
                ctl_rdata <= mem[ctl_idx];
        end
    end

    a_no_write_clash: assert property (@(posedge I2C_CLK)
        !(host_en && host_we && ctl_en && ctl_we && (host_idx == ctl_idx)));

endmodule

`default_nettype wire

// ==== rtl/i2c_regs.sv ====
// Host register bank on I2C_CLK. Registers 2 to 7 survive a soft reset and only RST clears them.
`timescale 1ns/100ps
`default_nettype none

module i2c_regs
    import i2c_pkg::*;
#(
    parameter int MEM_BYTES  = 16,
    parameter int ABUS_WIDTH = 16
) (
    input  wire         I2C_CLK,
    input  wire         RST,
    input  wire bus_addr_t bus_add,
    input  wire byte_t  bus_data_in,
    input  wire         bus_wr,
    input  wire         bus_rd,
    output byte_t       bus_data_out,
    output logic        mem_en,
    output logic        mem_we,
    output bus_addr_t   mem_add,
    output byte_t       mem_wdata,
    input  wire byte_t  mem_rdata,
    output i2c_cfg_t    cfg,
    output logic        go,
    output logic        soft_rst,
    input  wire         done_pulse,
    input  wire         no_ack_pulse
);

    localparam logic [ABUS_WIDTH-1:0] MEM_BASE = ABUS_WIDTH'(8);
    localparam logic [ABUS_WIDTH-1:0] MEM_END  = ABUS_WIDTH'(8 + MEM_BYTES);

    byte_t       regs_q [2:7];
    byte_t       rd_q;
    bus_addr_t   prev_add_q;
    i2c_status_t status_q;
    logic        in_mem;

    assign soft_rst = bus_wr && (bus_add == '0);
    assign go       = bus_wr && (bus_add == ABUS_WIDTH'(1));

    assign in_mem    = (bus_add >= MEM_BASE) && (bus_add < MEM_END);
    assign mem_en    = (bus_wr || bus_rd) && in_mem;
    assign mem_we    = bus_wr;
    assign mem_add   = bus_add - MEM_BASE;
    assign mem_wdata = bus_data_in;

    assign cfg = '{addr: regs_q[2], size: {regs_q[4], regs_q[3]}};

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            for (int i = 2; i < 8; i++) begin
                regs_q[i] <= '0;
            end
        end else if (bus_wr && (bus_add >= ABUS_WIDTH'(2)) && (bus_add < MEM_BASE)) begin
            regs_q[bus_add[2:0]] <= bus_data_in;
        end
    end

    // start clears both flags, the sequencer pulses set them again.
    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            status_q <= '{no_ack: 1'b0, done: 1'b1};
        end else if (go) begin
            status_q <= '0;
        end else begin
            if (done_pulse)
                status_q.done <= 1'b1;
            if (no_ack_pulse)
                status_q.no_ack <= 1'b1;
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (bus_rd) begin
            case (bus_add)
                ABUS_WIDTH'(0): rd_q <= VERSION;
                ABUS_WIDTH'(1): rd_q <= {6'd0, status_q};
                default:        rd_q <= (bus_add < MEM_BASE) ? regs_q[bus_add[2:0]] : '0;
            endcase
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST)
            prev_add_q <= '0;
        else if (bus_rd)
            prev_add_q <= bus_add;   // steers the output mux for the next cycle.
    end

    always_comb begin
        if (prev_add_q < MEM_BASE)
            bus_data_out = rd_q;
        else if (prev_add_q < MEM_END)
            bus_data_out = mem_rdata;
        else
            bus_data_out = '0;
    end

    // the sequencer reports only inside a transaction that the host started.
    a_pulse_in_transfer: assert property (@(posedge I2C_CLK) disable iff (RST)
        (done_pulse || no_ack_pulse) |-> !status_q.done);

endmodule

`default_nettype wire

// ==== rtl/i2c_pkg.sv ====
// Shared types for the I2C controller. bus_addr_t is sized by ABUS_WIDTH, which must match the module parameter.
`default_nettype none

package i2c_pkg;

    // ********************
    // widths and constants
    // ********************

    localparam int ABUS_WIDTH = 16;

    typedef logic [7:0]            byte_t;     // one byte on the host bus, in the buffer and on SDA.
    typedef logic [15:0]           count_t;    // transfer size and byte index.
    typedef logic [ABUS_WIDTH-1:0] bus_addr_t;

    localparam byte_t VERSION = 8'd1;

    // ********************
    // control types
    // ********************

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_STOP
    } seq_state_e;

    typedef enum logic [1:0] {
        OP_START,
        OP_WRITE_BYTE,
        OP_READ_BYTE,
        OP_STOP
    } shift_op_e;

    typedef struct packed {
        shift_op_e op;
        byte_t     data;     // byte to send on a write.
        logic      ack_lvl;  // level driven in the ACK bit of a read, 1 is NACK.
    } shift_req_t;

    typedef struct packed {
        byte_t data;
        logic  nack;         // sampled ACK bit.
    } shift_rsp_t;

    typedef struct packed {
        byte_t  addr;        // bit 0 selects a read.
        count_t size;
    } i2c_cfg_t;

    typedef struct packed {
        logic no_ack;
        logic done;
    } i2c_status_t;

endpackage

`default_nettype wire
